/* src/stream_demux_pkg.sv */
package stream_demux_pkg;

    // Beat payload widths.
    localparam int TDATA_W = 16;
    localparam int TDEST_W = 4;

    // Routed outputs and how many of them one stage owns.
    localparam int OUTPUTS = 6;
    localparam int GROUP = 3;

    // One stage per group, the last one may be short.
    localparam int STAGES = (OUTPUTS + GROUP - 1) / GROUP;

    // Transmit ports, the extract port sits at index OUTPUTS.
    localparam int PORTS = OUTPUTS + 1;
    localparam int PORT_W = $clog2(PORTS);

    typedef logic [TDATA_W-1:0] tdata_t;
    typedef logic [TDEST_W-1:0] tdest_t;
    typedef logic [PORT_W-1:0] port_t;

    // Routing table, entry i is the tdest value accepted by output i.
    // Values 2 to 7 are routed, everything else goes to extract.
    localparam tdest_t MAP [OUTPUTS] = '{
        4'd2,
        4'd3,
        4'd4,
        4'd5,
        4'd6,
        4'd7
    };

endpackage

/* src/stream_reg_slice.sv */
`timescale 1ns/1ns

module stream_reg_slice (
    input  logic                      aclk,
    input  logic                      areset_n,
    input  logic                      rx_tvalid,
    output logic                      rx_tready,
    input  stream_demux_pkg::tdata_t  rx_tdata,
    input  stream_demux_pkg::tdest_t  rx_tdest,
    input  logic                      rx_tlast,
    output logic                      tx_tvalid,
    input  logic                      tx_tready,
    output stream_demux_pkg::tdata_t  tx_tdata,
    output stream_demux_pkg::tdest_t  tx_tdest,
    output logic                      tx_tlast
);
    // Main register drives tx, skid register catches the beat taken
    // while tx is stalled.
    logic main_valid;
    logic skid_valid;
    logic main_valid_d;
    logic skid_valid_d;
    logic ready_q;
    logic rx_fire;
    logic load_main;
    logic load_skid;
    logic unload_skid;
    stream_demux_pkg::tdata_t skid_tdata;
    stream_demux_pkg::tdest_t skid_tdest;
    logic skid_tlast;

    assign rx_fire = rx_tvalid && ready_q;

    // Next state of both valid flags and the payload moves.
    always_comb begin
        main_valid_d = main_valid;
        skid_valid_d = skid_valid;
        load_main = 1'b0;
        load_skid = 1'b0;
        unload_skid = 1'b0;
        if (skid_valid) begin
            // Ready is low here, so only the drain of the skid entry matters.
            if (tx_tready) begin
                skid_valid_d = 1'b0;
                unload_skid = 1'b1;
            end
        end else if (rx_fire) begin
            if (!main_valid || tx_tready) begin
                main_valid_d = 1'b1;
                load_main = 1'b1;
            end else begin
                skid_valid_d = 1'b1;
                load_skid = 1'b1;
            end
        end else if (tx_tready) begin
            main_valid_d = 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            // Registered ready, high whenever the skid entry is free.
            ready_q <= !skid_valid_d;
        end
    end

    // Payload registers.
    always_ff @(posedge aclk) begin
        if (load_main) begin
            tx_tdata <= rx_tdata;
            tx_tdest <= rx_tdest;
            tx_tlast <= rx_tlast;
        end else if (unload_skid) begin
            tx_tdata <= skid_tdata;
            tx_tdest <= skid_tdest;
            tx_tlast <= skid_tlast;
        end
        if (load_skid) begin
            skid_tdata <= rx_tdata;
            skid_tdest <= rx_tdest;
            skid_tlast <= rx_tlast;
        end
    end

    assign tx_tvalid = main_valid;
    assign rx_tready = ready_q;

endmodule

/* src/stream_demux_stage.sv */
`timescale 1ns/1ns

module stream_demux_stage #(
    parameter int STAGE = 0
) (
    input  logic                      aclk,
    input  logic                      areset_n,
    input  logic                      prev_tvalid,
    output logic                      prev_tready,
    input  stream_demux_pkg::tdata_t  prev_tdata,
    input  stream_demux_pkg::tdest_t  prev_tdest,
    input  logic                      prev_tlast,
    output logic [stream_demux_pkg::GROUP-1:0] tx_tvalid,
    input  logic [stream_demux_pkg::GROUP-1:0] tx_tready,
    output stream_demux_pkg::tdata_t  tx_tdata [stream_demux_pkg::GROUP],
    output stream_demux_pkg::tdest_t  tx_tdest [stream_demux_pkg::GROUP],
    output logic [stream_demux_pkg::GROUP-1:0] tx_tlast,
    output logic                      next_tvalid,
    input  logic                      next_tready,
    output stream_demux_pkg::tdata_t  next_tdata,
    output stream_demux_pkg::tdest_t  next_tdest,
    output logic                      next_tlast
);
    localparam int GROUP = stream_demux_pkg::GROUP;
    // First table row owned by this stage.
    localparam int BASE = STAGE * GROUP;
    localparam int REMAIN = stream_demux_pkg::OUTPUTS - BASE;
    // The last stage may own fewer rows than a full group.
    localparam int WIDTH = (GROUP < REMAIN) ? GROUP : REMAIN;
    localparam int SEL_W = $clog2(GROUP + 1);

    // Lanes 0 to GROUP-1 are the local outputs, lane GROUP is next.
    logic [GROUP-1:0] hit;
    logic [SEL_W-1:0] sel;
    logic [GROUP:0] lane_tready;
    logic [GROUP:0] lane_rdy;
    logic [GROUP:0] lane_valid;
    logic [GROUP:0] lane_tlast;
    stream_demux_pkg::tdata_t lane_tdata [GROUP+1];
    stream_demux_pkg::tdest_t lane_tdest [GROUP+1];
    logic prev_fire;

    // Compare tdest with every owned row at once.
    for (genvar i = 0; i < GROUP; i++) begin : g_match
        if (i < WIDTH) begin : g_row
            assign hit[i] = (prev_tdest == stream_demux_pkg::MAP[BASE+i]);
        end else begin : g_pad
            assign hit[i] = 1'b0;
        end
    end

    // Lowest matching row wins, no match falls through to next.
    always_comb begin
        sel = SEL_W'(GROUP);
        for (int i = GROUP - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    // Only the chosen lane can hold off the incoming beat.
    assign prev_tready = lane_rdy[sel];
    assign prev_fire = prev_tvalid && prev_tready;
    assign lane_tready = {next_tready, tx_tready};

    for (genvar l = 0; l <= GROUP; l++) begin : g_lane
        logic main_valid;
        logic skid_valid;
        logic main_valid_d;
        logic skid_valid_d;
        logic rdy_q;
        logic load;
        logic load_main;
        logic load_skid;
        logic unload_skid;
        stream_demux_pkg::tdata_t main_tdata;
        stream_demux_pkg::tdest_t main_tdest;
        logic main_tlast;
        stream_demux_pkg::tdata_t skid_tdata;
        stream_demux_pkg::tdest_t skid_tdest;
        logic skid_tlast;

        assign load = prev_fire && (sel == SEL_W'(l));

        always_comb begin
            main_valid_d = main_valid;
            skid_valid_d = skid_valid;
            load_main = 1'b0;
            load_skid = 1'b0;
            unload_skid = 1'b0;
            if (skid_valid) begin
                if (lane_tready[l]) begin
                    skid_valid_d = 1'b0;
                    unload_skid = 1'b1;
                end
            end else if (load) begin
                // Straight into main when it is empty or draining.
                if (!main_valid || lane_tready[l]) begin
                    main_valid_d = 1'b1;
                    load_main = 1'b1;
                end else begin
                    skid_valid_d = 1'b1;
                    load_skid = 1'b1;
                end
            end else if (lane_tready[l]) begin
                main_valid_d = 1'b0;
            end
        end

        always_ff @(posedge aclk or negedge areset_n) begin
            if (!areset_n) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
                rdy_q <= 1'b0;
            end else begin
                main_valid <= main_valid_d;
                skid_valid <= skid_valid_d;
                rdy_q <= !skid_valid_d;
            end
        end

        always_ff @(posedge aclk) begin
            if (load_main) begin
                main_tdata <= prev_tdata;
                main_tdest <= prev_tdest;
                main_tlast <= prev_tlast;
            end else if (unload_skid) begin
                main_tdata <= skid_tdata;
                main_tdest <= skid_tdest;
                main_tlast <= skid_tlast;
            end
            if (load_skid) begin
                skid_tdata <= prev_tdata;
                skid_tdest <= prev_tdest;
                skid_tlast <= prev_tlast;
            end
        end

        assign lane_rdy[l] = rdy_q;
        assign lane_valid[l] = main_valid;
        assign lane_tlast[l] = main_tlast;
        assign lane_tdata[l] = main_tdata;
        assign lane_tdest[l] = main_tdest;
    end

    // Local lanes out to tx, last lane out to next.
    assign tx_tvalid = lane_valid[GROUP-1:0];
    assign tx_tlast = lane_tlast[GROUP-1:0];
    for (genvar i = 0; i < GROUP; i++) begin : g_tx
        assign tx_tdata[i] = lane_tdata[i];
        assign tx_tdest[i] = lane_tdest[i];
    end

    assign next_tvalid = lane_valid[GROUP];
    assign next_tlast = lane_tlast[GROUP];
    assign next_tdata = lane_tdata[GROUP];
    assign next_tdest = lane_tdest[GROUP];

endmodule

/* src/stream_demux_top.sv */
`timescale 1ns/1ns

module stream_demux_top (
    input  logic                      aclk,
    input  logic                      areset_n,
    input  logic                      rx_tvalid,
    output logic                      rx_tready,
    input  stream_demux_pkg::tdata_t  rx_tdata,
    input  stream_demux_pkg::tdest_t  rx_tdest,
    input  logic                      rx_tlast,
    output logic [stream_demux_pkg::PORTS-1:0] tx_tvalid,
    input  logic [stream_demux_pkg::PORTS-1:0] tx_tready,
    output stream_demux_pkg::tdata_t  tx_tdata [stream_demux_pkg::PORTS],
    output stream_demux_pkg::tdest_t  tx_tdest [stream_demux_pkg::PORTS],
    output logic [stream_demux_pkg::PORTS-1:0] tx_tlast
);
    localparam int GROUP = stream_demux_pkg::GROUP;
    localparam int STAGES = stream_demux_pkg::STAGES;
    localparam int OUTPUTS = stream_demux_pkg::OUTPUTS;

    // Chain links, link s feeds stage s and link STAGES feeds extract.
    logic [STAGES:0] link_tvalid;
    logic [STAGES:0] link_tready;
    logic [STAGES:0] link_tlast;
    stream_demux_pkg::tdata_t link_tdata [STAGES+1];
    stream_demux_pkg::tdest_t link_tdest [STAGES+1];

    // Input slice decouples rx from stage 0.
    stream_reg_slice u_rx_slice (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tdest  (rx_tdest),
        .rx_tlast  (rx_tlast),
        .tx_tvalid (link_tvalid[0]),
        .tx_tready (link_tready[0]),
        .tx_tdata  (link_tdata[0]),
        .tx_tdest  (link_tdest[0]),
        .tx_tlast  (link_tlast[0])
    );

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        localparam int BASE = s * GROUP;
        localparam int REMAIN = OUTPUTS - BASE;
        localparam int WIDTH = (GROUP < REMAIN) ? GROUP : REMAIN;

        logic [GROUP-1:0] st_tvalid;
        logic [GROUP-1:0] st_tready;
        logic [GROUP-1:0] st_tlast;
        stream_demux_pkg::tdata_t st_tdata [GROUP];
        stream_demux_pkg::tdest_t st_tdest [GROUP];

        stream_demux_stage #(
            .STAGE (s)
        ) u_stage (
            .aclk        (aclk),
            .areset_n    (areset_n),
            .prev_tvalid (link_tvalid[s]),
            .prev_tready (link_tready[s]),
            .prev_tdata  (link_tdata[s]),
            .prev_tdest  (link_tdest[s]),
            .prev_tlast  (link_tlast[s]),
            .tx_tvalid   (st_tvalid),
            .tx_tready   (st_tready),
            .tx_tdata    (st_tdata),
            .tx_tdest    (st_tdest),
            .tx_tlast    (st_tlast),
            .next_tvalid (link_tvalid[s+1]),
            .next_tready (link_tready[s+1]),
            .next_tdata  (link_tdata[s+1]),
            .next_tdest  (link_tdest[s+1]),
            .next_tlast  (link_tlast[s+1])
        );

        // Owned lanes map onto their tx ports, padding lanes stay idle.
        for (genvar n = 0; n < GROUP; n++) begin : g_port
            if (n < WIDTH) begin : g_used
                assign tx_tvalid[BASE+n] = st_tvalid[n];
                assign tx_tdata[BASE+n] = st_tdata[n];
                assign tx_tdest[BASE+n] = st_tdest[n];
                assign tx_tlast[BASE+n] = st_tlast[n];
                assign st_tready[n] = tx_tready[BASE+n];
            end else begin : g_pad
                assign st_tready[n] = 1'b0;
            end
        end
    end

    // Leftovers of the last stage leave through the extract port.
    stream_reg_slice u_extract_slice (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (link_tvalid[STAGES]),
        .rx_tready (link_tready[STAGES]),
        .rx_tdata  (link_tdata[STAGES]),
        .rx_tdest  (link_tdest[STAGES]),
        .rx_tlast  (link_tlast[STAGES]),
        .tx_tvalid (tx_tvalid[OUTPUTS]),
        .tx_tready (tx_tready[OUTPUTS]),
        .tx_tdata  (tx_tdata[OUTPUTS]),
        .tx_tdest  (tx_tdest[OUTPUTS]),
        .tx_tlast  (tx_tlast[OUTPUTS])
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic aclk,
    output logic areset_n
);
    // Free running clock, first rising edge half a period in.
    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // Reset spans RESET_CYCLES rising edges.
    // Release lands a quarter period later, clear of both edges.
    initial begin
        areset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #(PERIOD_NS / 4) areset_n = 1'b1;
    end

endmodule

/* testbench/tb_stream_demux.sv */
`timescale 1ns/1ns

module tb_stream_demux;
    localparam int PORTS = stream_demux_pkg::PORTS;
    localparam int OUTPUTS = stream_demux_pkg::OUTPUTS;
    localparam int GROUP = stream_demux_pkg::GROUP;
    localparam int STAGES = stream_demux_pkg::STAGES;
    localparam int PERIOD_NS = 40;
    localparam int SEED = 1;
    localparam int MAPPED_BEATS = 400;
    localparam int EXTRACT_BEATS = 200;
    localparam int LATENCY_BEATS = 2 * (1 << stream_demux_pkg::TDEST_W);
    localparam int BP_BEATS = 1000;
    localparam int TOTAL_BEATS = MAPPED_BEATS + EXTRACT_BEATS + LATENCY_BEATS + BP_BEATS;
    // Forty cycles per beat, plus room for reset and the drain phases.
    localparam int TIMEOUT_NS = TOTAL_BEATS * 40 * PERIOD_NS + 1000 * PERIOD_NS;
    localparam int DRAIN_CYCLES = 200;
    // Ways of choosing tdest.
    localparam int DEST_ANY = 0;
    localparam int DEST_MAPPED = 1;
    localparam int DEST_EXTRACT = 2;
    localparam int DEST_FIXED = 3;

    typedef stream_demux_pkg::tdata_t tdata_t;
    typedef stream_demux_pkg::tdest_t tdest_t;
    typedef stream_demux_pkg::port_t port_t;
    typedef logic [PORTS-1:0] flags_t;

    logic aclk;
    logic areset_n;
    logic rx_tvalid;
    logic rx_tready;
    tdata_t rx_tdata;
    tdest_t rx_tdest;
    logic rx_tlast;
    flags_t tx_tvalid;
    flags_t tx_tready;
    tdata_t tx_tdata [PORTS];
    tdest_t tx_tdest [PORTS];
    flags_t tx_tlast;

    // Reference model, one expected queue per port.
    tdata_t exp_data [PORTS][$];
    tdest_t exp_dest [PORTS][$];
    bit exp_last [PORTS][$];
    int exp_cycle [PORTS][$];

    string test_name;
    int test_errors;
    int total_errors;
    int tests_passed;
    int tests_failed;
    int cycle;
    bit latency_on;
    int fixed_dest;

    tb_clock #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) u_clock (
        .aclk     (aclk),
        .areset_n (areset_n)
    );

    stream_demux_top DUT (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tdest  (rx_tdest),
        .rx_tlast  (rx_tlast),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tdest  (tx_tdest),
        .tx_tlast  (tx_tlast)
    );

    // Port from the routing table, extract when no row matches.
    function automatic port_t route_port(input tdest_t dest);
        port_t port;
        port = port_t'(OUTPUTS);
        for (int i = 0; i < OUTPUTS; i++) begin
            if (stream_demux_pkg::MAP[i] == dest) begin
                port = port_t'(i);
            end
        end
        return port;
    endfunction

    // Edges from acceptance to transfer out with all tready high.
    // One edge per register on the way out.
    function automatic int expected_latency(input int port);
        return (port < OUTPUTS) ? 2 + port / GROUP : 2 + STAGES;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < PORTS; p++) begin
            n += exp_data[p].size();
        end
        return n;
    endfunction

    function automatic tdest_t pick_dest(input int mode);
        int v;
        case (mode)
            DEST_MAPPED: v = $urandom_range(7, 2);
            DEST_EXTRACT: begin
                // 0 and 1, or 8 to 15.
                v = $urandom_range(9, 0);
                if (v >= 2) begin
                    v = v + 6;
                end
            end
            DEST_FIXED: v = fixed_dest;
            default: v = $urandom_range(15, 0);
        endcase
        return tdest_t'(v);
    endfunction

    task automatic check_data(input int port, input tdata_t expected, input tdata_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: port %0d tdata expected %h actual %h",
                     test_name, port, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_dest(input int port, input tdest_t expected, input tdest_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: port %0d tdest expected %h actual %h",
                     test_name, port, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_last(input int port, input bit expected, input bit actual);
        if (actual !== expected) begin
            $display("ERROR %s: port %0d tlast expected %0b actual %0b",
                     test_name, port, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_port(input port_t expected, input port_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: beat port expected %0d actual %0d", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_valid(input flags_t expected, input flags_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: tx_tvalid expected %b actual %b", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_ready(input bit expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: rx_tready expected %0b actual %0b", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_latency(input int port, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: port %0d latency expected %0d actual %0d",
                     test_name, port, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // Sends count beats. Inputs change on falling edges only.
    // A beat held at a falling edge with rx_tready high has moved by the next one.
    task automatic run_stream(input int count, input int mode, input bit gaps, input bit bp);
        int sent;
        bit ready_seen;
        sent = 0;
        ready_seen = 1'b0;
        while (sent < count) begin
            @(negedge aclk);
            if (rx_tvalid && ready_seen) begin
                sent++;
                rx_tvalid = 1'b0;
            end
            if (bp) begin
                // Roughly three quarters of the ports ready per cycle.
                tx_tready = flags_t'($urandom) | flags_t'($urandom);
            end
            if (!rx_tvalid && sent < count && (!gaps || $urandom_range(3, 0) != 0)) begin
                rx_tvalid = 1'b1;
                rx_tdata = tdata_t'($urandom);
                rx_tdest = pick_dest(mode);
                rx_tlast = ($urandom_range(1, 0) == 1);
            end
            ready_seen = rx_tready;
        end
        tx_tready = '1;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(negedge aclk);
        while ((pending() != 0 || tx_tvalid != '0) && n < limit) begin
            @(negedge aclk);
            n++;
        end
        if (pending() != 0 || tx_tvalid != '0) begin
            $display("Test %s did not drain within %0d cycles", test_name, limit);
            test_errors++;
        end
    endtask

    // Monitor. Pushes accepted beats and checks every beat that leaves.
    always @(posedge aclk) begin
        port_t port;
        if (areset_n) begin
            if (rx_tvalid && rx_tready) begin
                port = route_port(rx_tdest);
                exp_data[port].push_back(rx_tdata);
                exp_dest[port].push_back(rx_tdest);
                exp_last[port].push_back(rx_tlast);
                exp_cycle[port].push_back(cycle);
            end
            for (int p = 0; p < PORTS; p++) begin
                if (tx_tvalid[p] && tx_tready[p]) begin
                    if (exp_data[p].size() == 0) begin
                        port = route_port(tx_tdest[p]);
                        if (port != port_t'(p)) begin
                            check_port(port, port_t'(p));
                        end else begin
                            $display("Test %s saw an extra beat on port %0d that was never sent",
                                     test_name, p);
                            test_errors++;
                        end
                    end else begin
                        check_data(p, exp_data[p].pop_front(), tx_tdata[p]);
                        check_dest(p, exp_dest[p].pop_front(), tx_tdest[p]);
                        check_last(p, exp_last[p].pop_front(), tx_tlast[p]);
                        if (latency_on) begin
                            check_latency(p, expected_latency(p), cycle - exp_cycle[p][0]);
                        end
                        void'(exp_cycle[p].pop_front());
                    end
                end
            end
            cycle++;
        end
    end

    // Watchdog.
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rx_tvalid = 1'b0;
        rx_tdata = '0;
        rx_tdest = '0;
        rx_tlast = 1'b0;
        tx_tready = '1;
        latency_on = 1'b0;
        fixed_dest = 0;
        cycle = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;

        start_test("reset");
        @(negedge aclk);
        while (!areset_n) begin
            check_valid('0, tx_tvalid);
            check_ready(1'b0, rx_tready);
            @(negedge aclk);
        end
        // First rising edge out of reset has passed.
        @(negedge aclk);
        check_valid('0, tx_tvalid);
        check_ready(1'b1, rx_tready);
        finish_test();

        start_test("mapped routing");
        run_stream(MAPPED_BEATS, DEST_MAPPED, 1'b0, 1'b0);
        wait_drain(DRAIN_CYCLES);
        finish_test();

        start_test("extract routing");
        run_stream(EXTRACT_BEATS, DEST_EXTRACT, 1'b0, 1'b0);
        wait_drain(DRAIN_CYCLES);
        finish_test();

        // Every tdest value twice, each beat alone in the pipeline.
        start_test("fixed latency");
        latency_on = 1'b1;
        for (int i = 0; i < LATENCY_BEATS; i++) begin
            fixed_dest = i % (1 << stream_demux_pkg::TDEST_W);
            run_stream(1, DEST_FIXED, 1'b0, 1'b0);
            wait_drain(DRAIN_CYCLES);
        end
        latency_on = 1'b0;
        finish_test();

        start_test("random back-pressure");
        run_stream(BP_BEATS, DEST_ANY, 1'b1, 1'b1);
        wait_drain(DRAIN_CYCLES);
        finish_test();

        start_test("drain");
        for (int p = 0; p < PORTS; p++) begin
            if (exp_data[p].size() != 0) begin
                $display("Port %0d still holds %0d beats that never came out",
                         p, exp_data[p].size());
                test_errors++;
            end
        end
        finish_test();

        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
src/stream_demux_pkg.sv
src/stream_reg_slice.sv
src/stream_demux_stage.sv
src/stream_demux_top.sv
testbench/tb_clock.sv
testbench/tb_stream_demux.sv

/* run.sh */
#!/bin/sh
# Build and run the stream demux testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_stream_demux \
    -f flist.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
